//--- src/isa_pkg.sv
package isa_pkg;

  localparam int data_bits   = 32;
  localparam int inst_size   = 4;   // PC step in bytes
  localparam int reg_no_bits = 4;
  localparam int imm_bits    = 16;
  localparam int op1_bits    = 6;
  localparam int op2_bits    = 8;

  // Low bit of each instruction field
  localparam int op1_lsb = 26;
  localparam int op2_lsb = 18;
  localparam int imm_lsb = 8;    // Overlaps rd
  localparam int rd_lsb  = 8;
  localparam int rs_lsb  = 4;
  localparam int rt_lsb  = 0;

  typedef enum logic [op1_bits-1:0] {
    op1_alur = 6'b000000,
    op1_beq  = 6'b001000,
    op1_blt  = 6'b001001,
    op1_ble  = 6'b001010,
    op1_bne  = 6'b001011,
    op1_jal  = 6'b001100,   // Decoded as a bubble
    op1_lw   = 6'b010010,
    op1_sw   = 6'b011010,
    op1_addi = 6'b100000,
    op1_andi = 6'b100100,
    op1_ori  = 6'b100101,
    op1_xori = 6'b100110
  } opcode1_e;

  typedef enum logic [op2_bits-1:0] {
    op2_eq   = 8'b00001000,
    op2_lt   = 8'b00001001,
    op2_le   = 8'b00001010,
    op2_ne   = 8'b00001011,
    op2_add  = 8'b00100000,
    op2_and  = 8'b00100100,
    op2_or   = 8'b00100101,
    op2_xor  = 8'b00100110,
    op2_sub  = 8'b00101000,
    op2_nand = 8'b00101100,
    op2_nor  = 8'b00101101,
    op2_xnor = 8'b00101110,
    op2_rshf = 8'b00110000,
    op2_lshf = 8'b00110001
  } opcode2_e;

  // One code per ALU function
  typedef enum logic [3:0] {
    alu_zero, alu_eq, alu_lt, alu_le, alu_ne,
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_nand, alu_nor, alu_xnor, alu_rshf, alu_lshf
  } alu_op_e;

endpackage

//--- src/io_map_pkg.sv
package io_map_pkg;

  // Memory-mapped board I/O
  localparam logic [31:0] addr_hex  = 32'hFFFFF000;
  localparam logic [31:0] addr_ledr = 32'hFFFFF020;
  localparam logic [31:0] addr_key  = 32'hFFFFF080;
  localparam logic [31:0] addr_sw   = 32'hFFFFF090;

  localparam int hex_bits  = 24;   // Six digits of four bits
  localparam int ledr_bits = 10;
  localparam int key_bits  = 4;
  localparam int sw_bits   = 10;

endpackage

//--- src/fetch_decode.sv
`timescale 1ns/10ps

module fetch_decode import isa_pkg::*; #(
  parameter logic [data_bits-1:0] start_pc = 32'h100
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [data_bits-1:0]   inst,
  input  logic                   wr_en,
  input  logic [reg_no_bits-1:0] wr_reg,
  input  logic [data_bits-1:0]   wr_data,
  output logic [data_bits-1:0]   fetch_addr,
  output alu_op_e                alu_op,
  output logic [data_bits-1:0]   operand_a,
  output logic [data_bits-1:0]   operand_b,
  output logic [data_bits-1:0]   store_data,
  output logic [reg_no_bits-1:0] dst_reg,
  output logic                   reg_we,
  output logic                   mem_re,
  output logic                   mem_we
);

  logic [data_bits-1:0]   inst_fe;
  logic [data_bits-1:0]   regs [0:(1 << reg_no_bits)-1];
  opcode1_e               op1;
  opcode2_e               op2;
  logic [data_bits-1:0]   imm_ext;
  logic [reg_no_bits-1:0] rd, rs, rt;
  logic [data_bits-1:0]   rs_val, rt_val;
  alu_op_e                dec_op;
  logic                   dec_b_imm, dec_use_rd;
  logic                   dec_reg_we, dec_mem_re, dec_mem_we;

  // PC and fetch latch for a memory with one cycle of latency
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetch_addr <= start_pc;
      inst_fe    <= '1;   // All ones decodes as a bubble
    end else begin
      fetch_addr <= fetch_addr + data_bits'(inst_size);
      inst_fe    <= inst;
    end
  end

  assign op1     = opcode1_e'(inst_fe[op1_lsb +: op1_bits]);
  assign op2     = opcode2_e'(inst_fe[op2_lsb +: op2_bits]);
  assign imm_ext = {{(data_bits-imm_bits){inst_fe[imm_lsb+imm_bits-1]}},
                    inst_fe[imm_lsb +: imm_bits]};
  assign rd      = inst_fe[rd_lsb +: reg_no_bits];
  assign rs      = inst_fe[rs_lsb +: reg_no_bits];
  assign rt      = inst_fe[rt_lsb +: reg_no_bits];

  always_comb begin
    dec_op     = alu_zero;
    dec_b_imm  = 1'b1;
    dec_use_rd = 1'b0;
    dec_reg_we = 1'b0;
    dec_mem_re = 1'b0;
    dec_mem_we = 1'b0;
    case (op1)
      op1_alur: begin
        dec_b_imm  = 1'b0;
        dec_use_rd = 1'b1;
        dec_reg_we = 1'b1;
        case (op2)
          op2_eq:   dec_op = alu_eq;
          op2_lt:   dec_op = alu_lt;
          op2_le:   dec_op = alu_le;
          op2_ne:   dec_op = alu_ne;
          op2_add:  dec_op = alu_add;
          op2_and:  dec_op = alu_and;
          op2_or:   dec_op = alu_or;
          op2_xor:  dec_op = alu_xor;
          op2_sub:  dec_op = alu_sub;
          op2_nand: dec_op = alu_nand;
          op2_nor:  dec_op = alu_nor;
          op2_xnor: dec_op = alu_xnor;
          op2_rshf: dec_op = alu_rshf;
          op2_lshf: dec_op = alu_lshf;
          default:  dec_op = alu_zero;   // Writes 0 to rd
        endcase
      end
      op1_lw: begin
        dec_op     = alu_add;   // Address is rs + imm
        dec_reg_we = 1'b1;
        dec_mem_re = 1'b1;
      end
      op1_sw: begin
        dec_op     = alu_add;
        dec_mem_we = 1'b1;
      end
      op1_addi: begin
        dec_op     = alu_add;
        dec_reg_we = 1'b1;
      end
      op1_andi: begin
        dec_op     = alu_and;
        dec_reg_we = 1'b1;
      end
      op1_ori: begin
        dec_op     = alu_or;
        dec_reg_we = 1'b1;
      end
      op1_xori: begin
        dec_op     = alu_xor;
        dec_reg_we = 1'b1;
      end
      default: dec_op = alu_zero;   // Branches, jal and unknown words
    endcase
  end

  // Write-first read ports
  assign rs_val = (wr_en && wr_reg == rs) ? wr_data : regs[rs];
  assign rt_val = (wr_en && wr_reg == rt) ? wr_data : regs[rt];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < (1 << reg_no_bits); i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_reg] <= wr_data;
    end
  end

  // Decode latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      alu_op <= alu_zero;
      reg_we <= 1'b0;
      mem_re <= 1'b0;
      mem_we <= 1'b0;
    end else begin
      alu_op <= dec_op;
      reg_we <= dec_reg_we;
      mem_re <= dec_mem_re;
      mem_we <= dec_mem_we;
    end
  end

  always_ff @(posedge clk) begin
    operand_a  <= rs_val;
    operand_b  <= dec_b_imm ? imm_ext : rt_val;
    store_data <= rt_val;
    dst_reg    <= dec_use_rd ? rd : rt;
  end

  a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    fetch_addr[1:0] == 2'b00);

endmodule

//--- src/execute.sv
`timescale 1ns/10ps

module execute import isa_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  alu_op_e                alu_op,
  input  logic [data_bits-1:0]   operand_a,
  input  logic [data_bits-1:0]   operand_b,
  input  logic [data_bits-1:0]   store_data,
  input  logic [reg_no_bits-1:0] dst_reg,
  input  logic                   reg_we,
  input  logic                   mem_re,
  input  logic                   mem_we,
  output logic [data_bits-1:0]   result,
  output logic [data_bits-1:0]   store_data_ex,
  output logic [reg_no_bits-1:0] dst_reg_ex,
  output logic                   reg_we_ex,
  output logic                   mem_re_ex,
  output logic                   mem_we_ex
);

  logic signed [data_bits-1:0] a_s, b_s;
  logic        [4:0]           shamt;
  logic        [data_bits-1:0] alu_out;

  assign a_s   = operand_a;
  assign b_s   = operand_b;
  assign shamt = operand_b[4:0];   // Shift amount from low five bits

  always_comb begin
    case (alu_op)
      alu_eq:   alu_out = {{(data_bits-1){1'b0}}, a_s == b_s};
      alu_lt:   alu_out = {{(data_bits-1){1'b0}}, a_s < b_s};
      alu_le:   alu_out = {{(data_bits-1){1'b0}}, a_s <= b_s};
      alu_ne:   alu_out = {{(data_bits-1){1'b0}}, a_s != b_s};
      alu_add:  alu_out = a_s + b_s;
      alu_sub:  alu_out = a_s - b_s;
      alu_and:  alu_out = a_s & b_s;
      alu_or:   alu_out = a_s | b_s;
      alu_xor:  alu_out = a_s ^ b_s;
      alu_nand: alu_out = ~(a_s & b_s);
      alu_nor:  alu_out = ~(a_s | b_s);
      alu_xnor: alu_out = a_s ~^ b_s;
      alu_rshf: alu_out = a_s >>> shamt;   // Keeps the sign
      alu_lshf: alu_out = a_s << shamt;
      default:  alu_out = '0;
    endcase
  end

  // Execute latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_we_ex <= 1'b0;
      mem_re_ex <= 1'b0;
      mem_we_ex <= 1'b0;
    end else begin
      reg_we_ex <= reg_we;
      mem_re_ex <= mem_re;
      mem_we_ex <= mem_we;
    end
  end

  always_ff @(posedge clk) begin
    result        <= alu_out;
    store_data_ex <= store_data;
    dst_reg_ex    <= dst_reg;
  end

  // Decode never asks for a load and a store together
  a_no_load_store: assert property (@(posedge clk) disable iff (reset)
    !(mem_re && mem_we));

endmodule

//--- src/io_stage.sv
`timescale 1ns/10ps

module io_stage import isa_pkg::*, io_map_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [data_bits-1:0]   result,
  input  logic [data_bits-1:0]   store_data_ex,
  input  logic [reg_no_bits-1:0] dst_reg_ex,
  input  logic                   reg_we_ex,
  input  logic                   mem_re_ex,
  input  logic                   mem_we_ex,
  input  logic [key_bits-1:0]    key,
  input  logic [sw_bits-1:0]     sw,
  output logic                   wr_en,
  output logic [reg_no_bits-1:0] wr_reg,
  output logic [data_bits-1:0]   wr_data,
  output logic [6:0]             hex0,
  output logic [6:0]             hex1,
  output logic [6:0]             hex2,
  output logic [6:0]             hex3,
  output logic [6:0]             hex4,
  output logic [6:0]             hex5,
  output logic [ledr_bits-1:0]   ledr
);

  logic [data_bits-1:0] load_val;
  logic [hex_bits-1:0]  hex_reg;

  // Active-low segments with bit 0 as segment a
  function automatic logic [6:0] seg7(input logic [3:0] digit);
    case (digit)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03;
      4'hC:    return 7'h46;
      4'hD:    return 7'h21;
      4'hE:    return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // Only keys and switches are readable
  always_comb begin
    if (result == addr_key)
      load_val = {{(data_bits-key_bits){1'b0}}, ~key};   // Buttons are active low
    else if (result == addr_sw)
      load_val = {{(data_bits-sw_bits){1'b0}}, sw};
    else
      load_val = '0;
  end

  assign wr_en   = reg_we_ex;
  assign wr_reg  = dst_reg_ex;
  assign wr_data = mem_re_ex ? load_val : result;

  // Stores to other addresses are dropped
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex_reg <= '0;
      ledr    <= '0;
    end else if (mem_we_ex) begin
      if (result == addr_hex)
        hex_reg <= store_data_ex[hex_bits-1:0];
      if (result == addr_ledr)
        ledr <= store_data_ex[ledr_bits-1:0];
    end
  end

  assign hex0 = seg7(hex_reg[3:0]);
  assign hex1 = seg7(hex_reg[7:4]);
  assign hex2 = seg7(hex_reg[11:8]);
  assign hex3 = seg7(hex_reg[15:12]);
  assign hex4 = seg7(hex_reg[19:16]);
  assign hex5 = seg7(hex_reg[23:20]);

  a_ledr_by_store: assert property (@(posedge clk) disable iff (reset)
    $changed(ledr) |-> $past(mem_we_ex && result == addr_ledr));

endmodule

//--- src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top import isa_pkg::*, io_map_pkg::*; #(
  parameter logic [data_bits-1:0] start_pc = 32'h100
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [data_bits-1:0] inst,
  input  logic [key_bits-1:0]  key,
  input  logic [sw_bits-1:0]   sw,
  output logic [data_bits-1:0] fetch_addr,
  output logic [6:0]           hex0,
  output logic [6:0]           hex1,
  output logic [6:0]           hex2,
  output logic [6:0]           hex3,
  output logic [6:0]           hex4,
  output logic [6:0]           hex5,
  output logic [ledr_bits-1:0] ledr
);

  // Decode latch to execute
  alu_op_e                alu_op;
  logic [data_bits-1:0]   operand_a, operand_b, store_data;
  logic [reg_no_bits-1:0] dst_reg;
  logic                   reg_we, mem_re, mem_we;

  // Execute latch to I/O
  logic [data_bits-1:0]   result, store_data_ex;
  logic [reg_no_bits-1:0] dst_reg_ex;
  logic                   reg_we_ex, mem_re_ex, mem_we_ex;

  logic                   wr_en;
  logic [reg_no_bits-1:0] wr_reg;
  logic [data_bits-1:0]   wr_data;

  fetch_decode #(.start_pc(start_pc)) u_fetch_decode (
    .clk, .reset, .inst, .wr_en, .wr_reg, .wr_data, .fetch_addr,
    .alu_op, .operand_a, .operand_b, .store_data, .dst_reg,
    .reg_we, .mem_re, .mem_we
  );

  execute u_execute (
    .clk, .reset, .alu_op, .operand_a, .operand_b, .store_data, .dst_reg,
    .reg_we, .mem_re, .mem_we, .result, .store_data_ex, .dst_reg_ex,
    .reg_we_ex, .mem_re_ex, .mem_we_ex
  );

  io_stage u_io_stage (
    .clk, .reset, .result, .store_data_ex, .dst_reg_ex, .reg_we_ex,
    .mem_re_ex, .mem_we_ex, .key, .sw, .wr_en, .wr_reg, .wr_data,
    .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .ledr
  );

endmodule

//--- sim/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import isa_pkg::*, io_map_pkg::*; ();

  localparam logic [data_bits-1:0] start_pc = 32'h100;
  localparam int stim_depth = 512;
  localparam int max_prog   = 256;
  localparam int max_events = 64;

  logic                 clk;
  logic                 reset;
  logic [data_bits-1:0] inst;
  logic [key_bits-1:0]  key;
  logic [sw_bits-1:0]   sw;
  logic [data_bits-1:0] fetch_addr;
  logic [6:0]           hex0, hex1, hex2, hex3, hex4, hex5;
  logic [ledr_bits-1:0] ledr;
  logic [41:0]          segs;

  logic [31:0]          stim [0:stim_depth-1];
  logic [31:0]          prog [0:max_prog-1];
  int                   in_cycle [0:max_events-1];
  logic [key_bits-1:0]  in_key [0:max_events-1];
  logic [sw_bits-1:0]   in_sw [0:max_events-1];
  int                   chk_cycle [0:max_events-1];
  logic [hex_bits-1:0]  chk_hex [0:max_events-1];
  logic [ledr_bits-1:0] chk_ledr [0:max_events-1];
  int                   prog_len, n_in, n_chk;
  int                   cycle, next_cycle, limit;
  int                   errors, checks_done;

  cpu_top #(.start_pc(start_pc)) uut (
    .clk, .reset, .inst, .key, .sw, .fetch_addr,
    .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .ledr
  );

  assign segs = {hex5, hex4, hex3, hex2, hex1, hex0};

  always #20 clk = ~clk;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Active-low pattern with bit 0 as segment a
  function automatic logic [6:0] segments_for(input logic [3:0] digit);
    logic [6:0] lit;   // Lit segments as gfedcba
    case (digit)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // Bubble word outside the program
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - start_pc) >> 2;
    if (addr >= start_pc && idx < 32'(prog_len))
      return prog[idx];
    return 32'hFFFFFFFF;
  endfunction

  task automatic check_outputs(input int idx);
    string tag;
    tag = $sformatf("cycle %0d", chk_cycle[idx]);
    compare({tag, " ledr"}, 32'(chk_ledr[idx]), 32'(ledr));
    for (int d = 0; d < 6; d++)
      compare($sformatf("%s hex%0d", tag, d),
              32'(segments_for(chk_hex[idx][4*d +: 4])), 32'(segs[7*d +: 7]));
    checks_done++;
  endtask

  // Records are tag 1 word, tag 2 cycle key sw, tag 3 cycle hex ledr
  task automatic load_stimulus;
    int pos;
    bit done;
    pos  = 0;
    done = 1'b0;
    for (int i = 0; i < stim_depth; i++)
      stim[i] = '0;
    $readmemh("sim/cpu_stimulus.txt", stim);
    while (!done) begin
      if (pos > stim_depth - 4 || stim[pos] == 32'd0) begin
        done = 1'b1;
      end else if (prog_len >= max_prog || n_in >= max_events || n_chk >= max_events) begin
        $display("stimulus file holds more records than the testbench can store");
        errors++;
        done = 1'b1;
      end else begin
        case (stim[pos])
          32'd1: begin
            prog[prog_len] = stim[pos+1];
            prog_len++;
            pos += 2;
          end
          32'd2: begin
            in_cycle[n_in] = int'(stim[pos+1]);
            in_key[n_in]   = stim[pos+2][key_bits-1:0];
            in_sw[n_in]    = stim[pos+3][sw_bits-1:0];
            n_in++;
            pos += 4;
          end
          32'd3: begin
            chk_cycle[n_chk] = int'(stim[pos+1]);
            chk_hex[n_chk]   = stim[pos+2][hex_bits-1:0];
            chk_ledr[n_chk]  = stim[pos+3][ledr_bits-1:0];
            if (chk_cycle[n_chk] + 20 > limit)
              limit = chk_cycle[n_chk] + 20;
            n_chk++;
            pos += 4;
          end
          default: begin
            $display("unknown record tag %0h at word %0d of the stimulus file",
                     stim[pos], pos);
            errors++;
            done = 1'b1;
          end
        endcase
      end
    end
  endtask

  // Memory answers the address seen before this edge
  always @(posedge clk) begin
    next_cycle = reset ? 0 : cycle + 1;
    inst  <= reset ? 32'hFFFFFFFF : word_at(fetch_addr);
    cycle <= next_cycle;
    for (int i = 0; i < n_in; i++)
      if (in_cycle[i] == next_cycle) begin
        key <= in_key[i];
        sw  <= in_sw[i];
      end
  end

  always @(negedge clk) begin
    if (!reset) begin
      compare($sformatf("pc cycle %0d", cycle),
              32'(start_pc + inst_size * cycle), fetch_addr);
      for (int i = 0; i < n_chk; i++)
        if (chk_cycle[i] == cycle)
          check_outputs(i);
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    inst        = 32'hFFFFFFFF;
    key         = '1;   // Buttons released
    sw          = '0;
    cycle       = 0;
    prog_len    = 0;
    n_in        = 0;
    n_chk       = 0;
    limit       = 20;
    errors      = 0;
    checks_done = 0;
    load_stimulus();
    if (n_chk == 0) begin
      $display("no output checks found in the stimulus file");
      errors++;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait (cycle >= limit);
    if (checks_done != n_chk) begin
      $display("only %0d of %0d output checks were reached", checks_done, n_chk);
      errors++;
    end
    $display("errors: %0d, output checks run: %0d", errors, checks_done);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- vlog.f
src/isa_pkg.sv
src/io_map_pkg.sv
src/fetch_decode.sv
src/execute.sv
src/io_stage.sv
src/cpu_top.sv
sim/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_io

sources:
  - src/isa_pkg.sv
  - src/io_map_pkg.sv
  - src/fetch_decode.sv
  - src/execute.sv
  - src/io_stage.sv
  - src/cpu_top.sv
  - target: simulation
    files:
      - sim/tb_cpu.sv

//--- sim/cpu_stimulus.txt
// All values hex. 1 word: program word from start_pc upward
// 2 cycle key sw: inputs from that cycle on. 3 cycle hex ledr: expected outputs
1 80012301   // addi r1, r0, 0x123
1 80FFFD02   // addi r2, r0, -3
1 68F02001   // sw r1 to ledr
1 68F02002   // sw r2 to ledr
1 80123403   // addi r3, r0, 0x1234
1 800FF004   // addi r4, r0, 0x0ff0
1 80000405   // addi r5, r0, 4
1 00800634   // add r6, r3, r4
1 00A00743   // sub r7, r4, r3
1 68F00006   // sw r6 to hex
1 68F00007   // sw r7 to hex
1 00900834   // and r8, r3, r4
1 00940934   // or r9, r3, r4
1 68F00008
1 68F00009
1 00980A34   // xor r10, r3, r4
1 00B40B34   // nor r11, r3, r4
1 68F0000A
1 68F0000B
1 00B80C34   // xnor r12, r3, r4
1 00C40D35   // lshf r13, r3, r5
1 68F0000C
1 68F0000D
1 00C00E75   // rshf r14, r7, r5
1 00240F73   // lt r15, r7, r3
1 68F0000E
1 68F0000F
1 900F0F31   // andi r1, r3, 0x0f0f
1 94A00542   // ori r2, r4, 0xa005
1 68F00001
1 68F00002
1 98555536   // xori r6, r3, 0x5555
1 FFFFFFFF   // bubble
1 68F00006
1 48F09007   // lw r7 from sw
1 48F08008   // lw r8 from key
1 68F02007   // sw r7 to ledr
1 68F00008   // sw r8 to hex
1 2000FF15   // beq
1 3000A0F5   // jal
1 68004003   // sw r3 to 0x40
1 68F01003   // sw r3 to 0xfffff010
1 68F02005   // sw r5 to ledr
2 00 F 000
2 14 5 2A5
3 01 000000 000
3 06 000000 000
3 07 000000 123
3 08 000000 3FD
3 0E 002224 3FD
3 0F FFFDBC 3FD
3 12 000230 3FD
3 13 001FF4 3FD
3 16 001DC4 3FD
3 17 FFE00B 3FD
3 1A FFE23B 3FD
3 1B 012340 3FD
3 1E FFFFDB 3FD
3 1F 000001 3FD
3 22 000204 3FD
3 23 FFAFF5 3FD
3 26 004761 3FD
3 29 004761 2A5
3 2A 00000A 2A5
3 2E 00000A 2A5
3 2F 00000A 004
